// ==== Bender.yml ====
package:
  name: exu

sources:
  - src/exu_pkg.sv
  - src/ex_operand_if.sv
  - src/ex_result_if.sv
  - src/ex_forward.sv
  - src/ex_alu.sv
  - src/ex_stage_reg.sv
  - src/exu_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/exu_tb.sv

// ==== bench/exu_model.svh ====
// reference model of the execute stage
// architectural register file, random instruction generation and the
// ISA meaning of every supported instruction

`ifndef EXU_MODEL_SVH
`define EXU_MODEL_SVH

typedef struct packed {
    exu_pkg::alu_op_e    alu_op;
    exu_pkg::branch_op_e branch_op;
    logic                load;
    logic                store;
    logic                dest_wen;
    exu_pkg::reg_addr_t  rs1;
    exu_pkg::reg_addr_t  rs2;
    exu_pkg::reg_addr_t  rd;
    logic [63:0]         pc;
    logic [63:0]         next_pc;
    logic [63:0]         imm;
    int                  jcnt;
    logic [63:0]         jaddr;
} instr_t;

// architectural state, written only at writeback
logic [63:0] rf [32];

function automatic logic [63:0] reg_value(input exu_pkg::reg_addr_t r);
    return (r == 5'd0) ? 64'd0 : rf[r];
endfunction

// memory contents seen by a load, spread over the whole address
function automatic logic [63:0] load_data(input logic [63:0] addr);
    return addr ^ {addr[31:0], addr[63:32]} ^ 64'h0f1e_2d3c_4b5a_6978;
endfunction

function automatic logic is_jump(input instr_t ins);
    return (ins.branch_op == exu_pkg::BR_JAL) || (ins.branch_op == exu_pkg::BR_JALR);
endfunction

function automatic logic [63:0] model_result(input instr_t ins);
    logic [63:0] a;
    logic [63:0] b;
    a = is_jump(ins) ? ins.pc : reg_value(ins.rs1);
    b = is_jump(ins) ? 64'd4 : ((ins.load || ins.store) ? ins.imm : reg_value(ins.rs2));
    case (ins.alu_op)
        exu_pkg::ALU_ADD:  return a + b;
        exu_pkg::ALU_SUB:  return a - b;
        exu_pkg::ALU_AND:  return a & b;
        exu_pkg::ALU_OR:   return a | b;
        exu_pkg::ALU_XOR:  return a ^ b;
        exu_pkg::ALU_SLL:  return a << b[5:0];
        exu_pkg::ALU_SRL:  return a >> b[5:0];
        exu_pkg::ALU_SRA:  return $unsigned($signed(a) >>> b[5:0]);
        exu_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        default:           return (a < b) ? 64'd1 : 64'd0;
    endcase
endfunction

function automatic logic model_taken(input instr_t ins);
    logic [63:0] a;
    logic [63:0] b;
    a = reg_value(ins.rs1);
    b = reg_value(ins.rs2);
    case (ins.branch_op)
        exu_pkg::BR_BEQ:  return a == b;
        exu_pkg::BR_BNE:  return a != b;
        exu_pkg::BR_BLT:  return $signed(a) < $signed(b);
        exu_pkg::BR_BGE:  return $signed(a) >= $signed(b);
        exu_pkg::BR_BLTU: return a < b;
        exu_pkg::BR_BGEU: return a >= b;
        exu_pkg::BR_JAL:  return 1'b1;
        exu_pkg::BR_JALR: return 1'b1;
        default:          return 1'b0;
    endcase
endfunction

function automatic logic [63:0] model_target(input instr_t ins);
    logic [63:0] sum;
    sum = ((ins.branch_op == exu_pkg::BR_JALR) ? reg_value(ins.rs1) : ins.pc) + ins.imm;
    return {sum[63:1], 1'b0};
endfunction

`endif

// ==== bench/exu_tb.sv ====
// testbench for the execute stage
// random instruction stream over a few registers, a load/store unit
// stand-in with writeback, and checks against the reference model

`timescale 1ns/1ps
`default_nettype none

module exu_tb;

    localparam int XLEN    = 64;
    localparam int N_INSTR = 2000;
    localparam int LIMIT   = N_INSTR * 8;

    logic clk, rst_n;
    logic decode_valid, decode_ready;
    exu_pkg::reg_addr_t rs1, rs2, rd, ex_rd, wb_rd;
    logic dest_wen, load, store, ls_flush, ls_ready, wb_valid, wb_dest_wen;
    exu_pkg::alu_op_e alu_op;
    exu_pkg::branch_op_e branch_op;
    logic [XLEN-1:0] pc, next_pc, operand1, operand2, operand3, operand4, wb_data;
    logic ex_valid, ex_dest_wen, ex_load, ex_store, jump_flag;
    logic [XLEN-1:0] ex_pc, ex_next_pc, ex_store_data, ex_result, jump_addr;

    `include "exu_model.svh"

    instr_t cur, slot;
    logic have_cur, slot_full, flush_prev, hold_prev, wb_v_nx, wb_w_nx;
    exu_pkg::reg_addr_t wb_rd_nx;
    logic [XLEN-1:0] wb_d_nx;
    logic [263:0] snap;
    int issued, jcnt, cycles;
    logic [XLEN-1:0] jaddr;

    exu_top #(.XLEN(XLEN)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
        $display("Simulation failed");
        $fatal(1, "value check stopped the run");
    endtask

    task automatic report_failure(input string what);
        $display("Error: %s", what);
        $display("Simulation failed");
        $fatal(1, "protocol check stopped the run");
    endtask

    function automatic instr_t random_instr();
        instr_t ins;
        int kind;
        kind = $urandom_range(0, 9);
        ins.rs1 = 5'($urandom_range(0, 3));
        ins.rs2 = 5'($urandom_range(0, 3));
        ins.rd = 5'($urandom_range(0, 3));
        ins.alu_op = exu_pkg::ALU_ADD;
        ins.branch_op = exu_pkg::BR_NONE;
        ins.load = kind == 5;
        ins.store = kind == 6;
        ins.dest_wen = !(kind == 6 || kind == 7 || kind == 8);
        ins.pc = {$urandom(), $urandom()} & ~64'd3;
        ins.next_pc = ins.pc + 64'd4;
        ins.imm = 64'($signed($urandom_range(0, 255)) - 128);
        ins.jcnt = 0;
        ins.jaddr = '0;
        if (kind < 5) begin
            ins.alu_op = exu_pkg::alu_op_e'($urandom_range(0, 9));
        end else if (kind == 5) begin
            ins.rs2 = 5'd0;
        end else if (kind == 6) begin
            ins.rd = 5'd0;
        end else if (kind < 9) begin
            ins.branch_op = exu_pkg::branch_op_e'($urandom_range(1, 6));
            ins.rd = 5'd0;
        end else begin
            ins.branch_op = $urandom_range(0, 1) ? exu_pkg::BR_JAL : exu_pkg::BR_JALR;
            ins.rs2 = 5'd0;
            if (ins.branch_op == exu_pkg::BR_JAL) begin
                ins.rs1 = 5'd0;
            end
        end
        return ins;
    endfunction

    // decode supplies register values as it last saw them
    task automatic drive_decode(input instr_t ins);
        decode_valid = 1'b1;
        {rs1, rs2, rd, dest_wen, load, store} =
            {ins.rs1, ins.rs2, ins.rd, ins.dest_wen, ins.load, ins.store};
        alu_op = ins.alu_op;
        branch_op = ins.branch_op;
        pc = ins.pc;
        next_pc = ins.next_pc;
        operand1 = is_jump(ins) ? ins.pc : reg_value(ins.rs1);
        operand2 = is_jump(ins) ? 64'd4 : ((ins.load || ins.store) ? ins.imm : reg_value(ins.rs2));
        operand3 = (ins.branch_op == exu_pkg::BR_JALR) ? reg_value(ins.rs1) :
                   (ins.store ? reg_value(ins.rs2) : ins.pc);
        operand4 = ins.imm;
    endtask

    // checks one item leaving EX/LS against the model
    task automatic check_item(input instr_t ins);
        logic tk;
        logic [63:0] tgt;
        logic [63:0] exp_res;
        logic [63:0] exp_npc;
        tk = model_taken(ins);
        tgt = model_target(ins);
        exp_res = model_result(ins);
        exp_npc = tk ? tgt : ins.next_pc;
        assert (ex_result == exp_res) else report_mismatch("result", exp_res, ex_result);
        assert (ex_pc == ins.pc) else report_mismatch("pc", ins.pc, ex_pc);
        assert (ex_rd == ins.rd) else report_mismatch("rd", 64'(ins.rd), 64'(ex_rd));
        assert (ex_dest_wen == ins.dest_wen)
            else report_mismatch("dest_wen", 64'(ins.dest_wen), 64'(ex_dest_wen));
        assert (ex_load == ins.load)
            else report_mismatch("load", 64'(ins.load), 64'(ex_load));
        assert (ex_store == ins.store)
            else report_mismatch("store", 64'(ins.store), 64'(ex_store));
        assert (ex_next_pc == exp_npc) else report_mismatch("next_pc", exp_npc, ex_next_pc);
        if (ins.store) begin
            assert (ex_store_data == reg_value(ins.rs2))
                else report_mismatch("store_data", reg_value(ins.rs2), ex_store_data);
        end
        assert (ins.jcnt == (tk ? 1 : 0))
            else report_mismatch("jump strobe count", tk ? 64'd1 : 64'd0, 64'(ins.jcnt));
        if (tk) begin
            assert (ins.jaddr == tgt) else report_mismatch("jump_addr", tgt, ins.jaddr);
        end
    endtask

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            assert (cycles < LIMIT)
                else report_failure("run did not finish within the cycle limit");
        end
    end

    initial begin
        void'($urandom(32'h25e0_3a81));
        rst_n = 1'b0;
        decode_valid = 1'b0;
        {rs1, rs2, rd, dest_wen, load, store} = '0;
        alu_op = exu_pkg::ALU_ADD;
        branch_op = exu_pkg::BR_NONE;
        {pc, next_pc, operand1, operand2, operand3, operand4} = '0;
        {ls_flush, ls_ready, wb_valid, wb_dest_wen, wb_rd, wb_data} = '0;
        rf[0] = '0;
        for (int i = 1; i < 32; i++) begin
            rf[i] = {$urandom(), $urandom()};
        end
        {have_cur, slot_full, flush_prev, hold_prev} = '0;
        issued = 0;
        jcnt = 0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        while (!(issued >= N_INSTR && !have_cur && !slot_full && !wb_valid)) begin
            @(posedge clk);
            if (flush_prev) begin
                assert (!ex_valid) else report_failure("ex_valid still high after a flush");
            end
            if (hold_prev) begin
                assert (ex_valid && snap == {ex_pc, ex_next_pc, ex_rd, ex_dest_wen, ex_load,
                        ex_store, ex_store_data, ex_result})
                    else report_failure("EX/LS register changed while ls_ready was low");
            end
            if (decode_valid && ex_valid && ex_load && ex_dest_wen && ex_rd != 5'd0 &&
                (ex_rd == rs1 || ex_rd == rs2)) begin
                assert (!decode_ready)
                    else report_failure("decode_ready high during a load-use hazard");
            end
            assert (!jump_flag || decode_valid)
                else report_failure("jump_flag without a decode item");
            if (decode_valid && jump_flag) begin
                jcnt++;
                jaddr = jump_addr;
            end
            // writeback commits first, then the leaving item sees it
            if (wb_valid && wb_dest_wen && wb_rd != 5'd0) begin
                rf[wb_rd] = wb_data;
            end
            {wb_v_nx, wb_w_nx, wb_rd_nx, wb_d_nx} = '0;
            if (ex_valid && ls_flush) begin
                slot_full = 1'b0;
            end else if (ex_valid && ls_ready) begin
                assert (slot_full) else report_failure("item left EX/LS that was never accepted");
                check_item(slot);
                slot_full = 1'b0;
                {wb_v_nx, wb_w_nx, wb_rd_nx} = {1'b1, ex_dest_wen, ex_rd};
                wb_d_nx = ex_load ? load_data(ex_result) : ex_result;
            end
            if (decode_valid && decode_ready && !ls_flush) begin
                slot = cur;
                slot.jcnt = jcnt;
                slot.jaddr = jaddr;
                slot_full = 1'b1;
            end
            if (have_cur && ((decode_valid && decode_ready) || ls_flush)) begin
                have_cur = 1'b0;
                jcnt = 0;
            end
            hold_prev = ex_valid && !ls_ready && !ls_flush;
            snap = {ex_pc, ex_next_pc, ex_rd, ex_dest_wen, ex_load, ex_store,
                    ex_store_data, ex_result};
            flush_prev = ls_flush;
            #1;
            ls_flush = (issued < N_INSTR) && ($urandom_range(0, 99) == 0);
            ls_ready = !ls_flush && ($urandom_range(0, 3) != 0);
            {wb_valid, wb_dest_wen, wb_rd, wb_data} = {wb_v_nx, wb_w_nx, wb_rd_nx, wb_d_nx};
            // fields stay as driven until the item is accepted or flushed
            if (!have_cur && issued < N_INSTR) begin
                cur = random_instr();
                have_cur = 1'b1;
                issued++;
                drive_decode(cur);
            end else if (!have_cur) begin
                decode_valid = 1'b0;
            end
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+bench
src/exu_pkg.sv
src/ex_operand_if.sv
src/ex_result_if.sv
src/ex_forward.sv
src/ex_alu.sv
src/ex_stage_reg.sv
src/exu_top.sv
bench/exu_tb.sv

// ==== src/ex_alu.sv ====
// execute stage integer datapath
// ALU on op_a/op_b, branch condition on the same pair, jump target adder
// and the choice of the next pc. purely combinational

`timescale 1ns/1ps
`default_nettype none

module ex_alu #(
    parameter int XLEN = 64
) (
    input  exu_pkg::alu_op_e       alu_op,
    input  exu_pkg::branch_op_e    branch_op,
    input  logic [XLEN-1:0]        next_pc,
    ex_operand_if.alu              opnd,
    ex_result_if.alu               res
);

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0]  shamt;
    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic [XLEN-1:0] tgt_sum;
    logic [XLEN-1:0] target;
    logic            taken;

    assign shamt = opnd.op_b[SHW-1:0];

    // shared by set-less-than and the branch compare
    assign eq   = (opnd.op_a == opnd.op_b);
    assign lt_s = ($signed(opnd.op_a) < $signed(opnd.op_b));
    assign lt_u = (opnd.op_a < opnd.op_b);

    // ********************
    // integer ALU
    // ********************
    always_comb begin
        case (alu_op)
            exu_pkg::ALU_ADD:  res.result = opnd.op_a + opnd.op_b;
            exu_pkg::ALU_SUB:  res.result = opnd.op_a - opnd.op_b;
            exu_pkg::ALU_AND:  res.result = opnd.op_a & opnd.op_b;
            exu_pkg::ALU_OR:   res.result = opnd.op_a | opnd.op_b;
            exu_pkg::ALU_XOR:  res.result = opnd.op_a ^ opnd.op_b;
            exu_pkg::ALU_SLL:  res.result = opnd.op_a << shamt;
            exu_pkg::ALU_SRL:  res.result = opnd.op_a >> shamt;
            exu_pkg::ALU_SRA:  res.result = $unsigned($signed(opnd.op_a) >>> shamt);
            exu_pkg::ALU_SLT:  res.result = {{(XLEN-1){1'b0}}, lt_s};
            exu_pkg::ALU_SLTU: res.result = {{(XLEN-1){1'b0}}, lt_u};
            default:           res.result = '0;
        endcase
    end

    // ********************
    // control flow
    // ********************
    always_comb begin
        case (branch_op)
            exu_pkg::BR_BEQ:  taken = eq;
            exu_pkg::BR_BNE:  taken = !eq;
            exu_pkg::BR_BLT:  taken = lt_s;
            exu_pkg::BR_BGE:  taken = !lt_s;
            exu_pkg::BR_BLTU: taken = lt_u;
            exu_pkg::BR_BGEU: taken = !lt_u;
            exu_pkg::BR_JAL:  taken = 1'b1;
            exu_pkg::BR_JALR: taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    // pc + imm for branches and jal, rs1 + imm for jalr
    assign tgt_sum = opnd.tgt_base + opnd.tgt_ofs;
    assign target  = {tgt_sum[XLEN-1:1], 1'b0};

    assign res.taken      = taken;
    assign res.target     = target;
    assign res.next_pc    = taken ? target : next_pc;
    assign res.store_data = opnd.store_data;

endmodule

`default_nettype wire

// ==== src/ex_forward.sv ====
// execute stage operand forwarding
// resolves rs1/rs2 against the EX/LS register, the writeback port and
// the held sources, in that order, before falling back to decode values.
// a held source keeps a value that retired while the item was stalled.
// also flags a load-use hazard against the item sitting in EX/LS

`timescale 1ns/1ps
`default_nettype none

module ex_forward #(
    parameter int XLEN = 64
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ls_flush,
    input  logic                   decode_valid,
    input  logic                   accept,
    input  exu_pkg::reg_addr_t     rs1,
    input  exu_pkg::reg_addr_t     rs2,
    input  exu_pkg::branch_op_e    branch_op,
    input  logic                   store,
    input  logic [XLEN-1:0]        operand1,
    input  logic [XLEN-1:0]        operand2,
    input  logic [XLEN-1:0]        operand3,
    input  logic [XLEN-1:0]        operand4,
    input  logic                   ex_valid,
    input  logic                   ex_dest_wen,
    input  logic                   ex_load,
    input  exu_pkg::reg_addr_t     ex_rd,
    input  logic [XLEN-1:0]        ex_result,
    input  logic                   wb_valid,
    input  logic                   wb_dest_wen,
    input  exu_pkg::reg_addr_t     wb_rd,
    input  logic [XLEN-1:0]        wb_data,
    output logic                   hazard,
    ex_operand_if.fwd              opnd
);

    // index 0 is rs1, index 1 is rs2
    exu_pkg::reg_addr_t src_addr [2];
    logic               ex_hit [2];
    logic               wb_hit [2];
    logic               held_valid [2];
    logic [XLEN-1:0]    held_data [2];
    logic               fwd_hit [2];
    logic [XLEN-1:0]    fwd_val [2];
    logic               jalr;

    assign src_addr[0] = rs1;
    assign src_addr[1] = rs2;

    // ********************
    // per-source forwarding
    // ********************
    for (genvar i = 0; i < 2; i++) begin : g_src
        assign ex_hit[i] = ex_valid && ex_dest_wen && (src_addr[i] != '0) &&
                           (ex_rd == src_addr[i]);
        assign wb_hit[i] = wb_valid && wb_dest_wen && (src_addr[i] != '0) &&
                           (wb_rd == src_addr[i]);

        assign fwd_hit[i] = ex_hit[i] || wb_hit[i] || held_valid[i];

        // youngest producer wins
        always_comb begin
            if (ex_hit[i]) begin
                fwd_val[i] = ex_result;
            end else if (wb_hit[i]) begin
                fwd_val[i] = wb_data;
            end else begin
                fwd_val[i] = held_data[i];
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                held_valid[i] <= 1'b0;
            end else if (ls_flush || accept) begin
                held_valid[i] <= 1'b0;
            end else if (decode_valid && wb_hit[i]) begin
                held_valid[i] <= 1'b1;
            end
        end

        // value retiring under a stalled item
        always_ff @(posedge clk) begin
            if (decode_valid && wb_hit[i] && !accept) begin
                held_data[i] <= wb_data;
            end
        end
    end

    // ********************
    // operand steering
    // ********************
    assign jalr = (branch_op == exu_pkg::BR_JALR);

    // jalr takes pc in operand1 and its rs1 value in operand3
    assign opnd.op_a     = (fwd_hit[0] && !jalr) ? fwd_val[0] : operand1;
    assign opnd.tgt_base = (fwd_hit[0] && jalr) ? fwd_val[0] : operand3;

    // a store takes its offset in operand2 and the rs2 value in operand3
    assign opnd.op_b       = (fwd_hit[1] && !store) ? fwd_val[1] : operand2;
    assign opnd.store_data = fwd_hit[1] ? fwd_val[1] : operand3;
    assign opnd.tgt_ofs    = operand4;

    // load data is not available before writeback
    assign hazard = ex_valid && ex_load && ex_dest_wen && (ex_rd != '0) &&
                    ((ex_rd == rs1) || (ex_rd == rs2));

    // a held value belongs to the item still waiting in decode
    a_held_only_while_waiting : assert property (
        @(posedge clk) disable iff (!rst_n)
        (held_valid[0] || held_valid[1]) |-> decode_valid
    );

endmodule

`default_nettype wire

// ==== src/ex_operand_if.sv ====
// resolved operand bundle
// carries the forwarded operands from the forwarding block to the ALU

`timescale 1ns/1ps
`default_nettype none

interface ex_operand_if #(
    parameter int XLEN = 64
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] tgt_base;
    logic [XLEN-1:0] tgt_ofs;
    logic [XLEN-1:0] store_data;

    modport fwd (output op_a, output op_b, output tgt_base, output tgt_ofs,
                 output store_data);

    modport alu (input op_a, input op_b, input tgt_base, input tgt_ofs,
                 input store_data);

endinterface

`default_nettype wire

// ==== src/ex_result_if.sv ====
// ALU outcome bundle
// carries result, branch decision and next pc to the EX/LS register

`timescale 1ns/1ps
`default_nettype none

interface ex_result_if #(
    parameter int XLEN = 64
);

    logic [XLEN-1:0] result;
    logic            taken;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] store_data;

    modport alu (output result, output taken, output target, output next_pc,
                 output store_data);

    modport stage (input result, input taken, input target, input next_pc,
                   input store_data);

endinterface

`default_nettype wire

// ==== src/ex_stage_reg.sv ====
// execute stage output register
// upstream and downstream valid/ready handshake, the EX/LS pipeline
// register with back-pressure and flush, and the one-shot jump redirect
// strobe toward fetch

`timescale 1ns/1ps
`default_nettype none

module ex_stage_reg #(
    parameter int XLEN = 64
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   decode_valid,
    input  logic                   hazard,
    input  logic                   ls_flush,
    input  logic                   ls_ready,
    input  logic [XLEN-1:0]        pc,
    input  exu_pkg::reg_addr_t     rd,
    input  logic                   dest_wen,
    input  logic                   load,
    input  logic                   store,
    output logic                   decode_ready,
    output logic                   accept,
    output logic                   jump_flag,
    output logic [XLEN-1:0]        jump_addr,
    output logic                   ex_valid,
    output logic [XLEN-1:0]        ex_pc,
    output logic [XLEN-1:0]        ex_next_pc,
    output exu_pkg::reg_addr_t     ex_rd,
    output logic                   ex_dest_wen,
    output logic                   ex_load,
    output logic                   ex_store,
    output logic [XLEN-1:0]        ex_store_data,
    output logic [XLEN-1:0]        ex_result,
    ex_result_if.stage             res
);

    logic slot_free;
    logic jump_sent;

    // ********************
    // handshake
    // ********************
    assign slot_free    = !ex_valid || ls_ready;
    assign decode_ready = decode_valid && slot_free && !hazard;
    assign accept       = decode_valid && decode_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (ls_flush) begin
            ex_valid <= 1'b0;
        end else if (slot_free) begin
            ex_valid <= accept;
        end
    end

    // EX/LS payload
    always_ff @(posedge clk) begin
        if (accept && !ls_flush) begin
            ex_pc         <= pc;
            ex_next_pc    <= res.next_pc;
            ex_rd         <= rd;
            ex_dest_wen   <= dest_wen;
            ex_load       <= load;
            ex_store      <= store;
            ex_store_data <= res.store_data;
            ex_result     <= res.result;
        end
    end

    // ********************
    // jump redirect
    // ********************
    // remembers that fetch was redirected while the item still waits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jump_sent <= 1'b0;
        end else if (ls_flush || accept) begin
            jump_sent <= 1'b0;
        end else if (jump_flag) begin
            jump_sent <= 1'b1;
        end
    end

    assign jump_flag = decode_valid && res.taken && !hazard && !jump_sent;
    assign jump_addr = res.target;

    a_hold_under_backpressure : assert property (
        @(posedge clk) disable iff (!rst_n)
        (ex_valid && !ls_ready && !ls_flush) |=>
            (ex_valid && $stable({ex_pc, ex_next_pc, ex_rd, ex_dest_wen, ex_load,
                                  ex_store, ex_store_data, ex_result}))
    );

    // a redirect already sent stays valid while the item waits for the slot
    a_jump_stable_while_waiting : assert property (
        @(posedge clk) disable iff (!rst_n)
        (jump_flag && !accept && !ls_flush) |=>
            (decode_valid && !hazard && res.taken && $stable(res.target))
    );

endmodule

`default_nettype wire

// ==== src/exu_pkg.sv ====
// execute stage shared definitions
// operation encodings for the integer ALU and the control-flow unit,
// and the architectural register index type

`default_nettype none

package exu_pkg;

    // register index, x0 is the hard-wired zero
    typedef logic [4:0] reg_addr_t;

    // integer ALU operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // control-flow kind of the instruction
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_BEQ  = 4'd1,
        BR_BNE  = 4'd2,
        BR_BLT  = 4'd3,
        BR_BGE  = 4'd4,
        BR_BLTU = 4'd5,
        BR_BGEU = 4'd6,
        BR_JAL  = 4'd7,
        BR_JALR = 4'd8
    } branch_op_e;

endpackage

`default_nettype wire

// ==== src/exu_top.sv ====
// execute stage of the 64-bit in-order pipeline
// forwarding and hazard check, integer ALU with branch and jump resolution,
// and the EX/LS register toward the load/store unit

`timescale 1ns/1ps
`default_nettype none

module exu_top #(
    parameter int XLEN = 64
) (
    input  logic                   clk,
    input  logic                   rst_n,
    // decode side
    input  logic                   decode_valid,
    output logic                   decode_ready,
    input  exu_pkg::reg_addr_t     rs1,
    input  exu_pkg::reg_addr_t     rs2,
    input  exu_pkg::reg_addr_t     rd,
    input  logic                   dest_wen,
    input  exu_pkg::alu_op_e       alu_op,
    input  exu_pkg::branch_op_e    branch_op,
    input  logic                   load,
    input  logic                   store,
    input  logic [XLEN-1:0]        pc,
    input  logic [XLEN-1:0]        next_pc,
    input  logic [XLEN-1:0]        operand1,
    input  logic [XLEN-1:0]        operand2,
    input  logic [XLEN-1:0]        operand3,
    input  logic [XLEN-1:0]        operand4,
    // load/store side
    input  logic                   ls_flush,
    input  logic                   ls_ready,
    output logic                   ex_valid,
    output logic [XLEN-1:0]        ex_pc,
    output logic [XLEN-1:0]        ex_next_pc,
    output exu_pkg::reg_addr_t     ex_rd,
    output logic                   ex_dest_wen,
    output logic                   ex_load,
    output logic                   ex_store,
    output logic [XLEN-1:0]        ex_store_data,
    output logic [XLEN-1:0]        ex_result,
    // writeback port
    input  logic                   wb_valid,
    input  exu_pkg::reg_addr_t     wb_rd,
    input  logic                   wb_dest_wen,
    input  logic [XLEN-1:0]        wb_data,
    // fetch side
    output logic                   jump_flag,
    output logic [XLEN-1:0]        jump_addr
);

    logic hazard;
    logic accept;

    ex_operand_if #(.XLEN(XLEN)) u_opnd_if ();
    ex_result_if  #(.XLEN(XLEN)) u_res_if ();

    ex_forward #(.XLEN(XLEN)) u_forward (
        .clk          (clk),
        .rst_n        (rst_n),
        .ls_flush     (ls_flush),
        .decode_valid (decode_valid),
        .accept       (accept),
        .rs1          (rs1),
        .rs2          (rs2),
        .branch_op    (branch_op),
        .store        (store),
        .operand1     (operand1),
        .operand2     (operand2),
        .operand3     (operand3),
        .operand4     (operand4),
        .ex_valid     (ex_valid),
        .ex_dest_wen  (ex_dest_wen),
        .ex_load      (ex_load),
        .ex_rd        (ex_rd),
        .ex_result    (ex_result),
        .wb_valid     (wb_valid),
        .wb_dest_wen  (wb_dest_wen),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .hazard       (hazard),
        .opnd         (u_opnd_if.fwd)
    );

    ex_alu #(.XLEN(XLEN)) u_alu (
        .alu_op    (alu_op),
        .branch_op (branch_op),
        .next_pc   (next_pc),
        .opnd      (u_opnd_if.alu),
        .res       (u_res_if.alu)
    );

    ex_stage_reg #(.XLEN(XLEN)) u_stage_reg (
        .clk           (clk),
        .rst_n         (rst_n),
        .decode_valid  (decode_valid),
        .hazard        (hazard),
        .ls_flush      (ls_flush),
        .ls_ready      (ls_ready),
        .pc            (pc),
        .rd            (rd),
        .dest_wen      (dest_wen),
        .load          (load),
        .store         (store),
        .decode_ready  (decode_ready),
        .accept        (accept),
        .jump_flag     (jump_flag),
        .jump_addr     (jump_addr),
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_next_pc    (ex_next_pc),
        .ex_rd         (ex_rd),
        .ex_dest_wen   (ex_dest_wen),
        .ex_load       (ex_load),
        .ex_store      (ex_store),
        .ex_store_data (ex_store_data),
        .ex_result     (ex_result),
        .res           (u_res_if.stage)
    );

endmodule

`default_nettype wire
